//--- src/mac_pkg.sv
//////////////////////////////
// neuron mac shared defs
//////////////////////////////
`default_nettype none

package mac_pkg;

	localparam int PIXEL_W      = 16;   // signed input pixel
	localparam int WEIGHT_W     = 16;   // one lane weight
	localparam int ACC_W        = 32;   // accumulator, wraps mod 2^32
	localparam int LANES        = 4;    // accumulators per hidden word
	localparam int HID_DEPTH    = 16;   // hidden words
	localparam int HID_ADDR_W   = 4;
	localparam int NEURONS      = 64;   // HID_DEPTH * LANES
	localparam int NEURON_IDX_W = 6;

	// last accepted strobe until its write has landed
	localparam int DRAIN_CYCLES = 2;

	typedef logic signed [PIXEL_W-1:0]        pixel_t;
	typedef logic [LANES*WEIGHT_W-1:0]        weight_word_t;  // lane 0 in low bits
	typedef logic [LANES*ACC_W-1:0]           acc_word_t;     // lane 0 in low bits
	typedef logic [HID_ADDR_W-1:0]            hid_addr_t;
	typedef logic [NEURON_IDX_W-1:0]          neuron_idx_t;   // addr * LANES + lane

	// layer control
	typedef enum logic [1:0] {
		SEQ_IDLE,   // waiting for start
		SEQ_RUN,    // taking input strobes
		SEQ_DRAIN,  // last writes in flight
		SEQ_DUMP    // reader streaming results
	} seq_state_t;

endpackage

`default_nettype wire

//--- src/input_sequencer.sv
//////////////////////////////
// input sequencer
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module input_sequencer (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_start,      // only seen in idle
	input  logic                  i_valid,      // only seen in run
	input  mac_pkg::pixel_t       i_pixel,
	input  mac_pkg::weight_word_t i_weights,
	input  logic                  i_last,
	input  logic                  i_dump_done,  // from result reader
	output logic                  o_busy,
	output logic                  o_op_valid,
	output mac_pkg::pixel_t       o_pixel,
	output mac_pkg::weight_word_t o_weights,
	output mac_pkg::hid_addr_t    o_addr,
	output logic                  o_first,      // overwrite instead of add
	output logic                  o_dump_start
);
	import mac_pkg::*;

	seq_state_t state;
	hid_addr_t  addr;           // hidden word for the next strobe
	logic       first;          // still in pixel 0
	logic [1:0] drain_cnt;
	logic       accept;
	logic       at_last_addr;

	assign accept       = i_valid && (state == SEQ_RUN);
	assign at_last_addr = (addr == hid_addr_t'(HID_DEPTH - 1));
	assign o_busy       = (state != SEQ_IDLE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= SEQ_IDLE;
			addr         <= '0;
			first        <= 1'b0;
			drain_cnt    <= '0;
			o_op_valid   <= 1'b0;
			o_dump_start <= 1'b0;
		end else begin
			o_op_valid   <= accept;     // one strobe per accepted input
			o_dump_start <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (i_start) begin
						state <= SEQ_RUN;
						addr  <= '0;
						first <= 1'b1;      // first pass clears the memory
					end
				end
				SEQ_RUN: begin
					if (i_valid) begin
						addr <= addr + 1'b1;  // wraps 15 -> 0
						if (at_last_addr) begin
							first <= 1'b0;
							// i_last elsewhere is ignored
							if (i_last) begin
								state     <= SEQ_DRAIN;
								drain_cnt <= '0;
							end
						end
					end
				end
				SEQ_DRAIN: begin
					drain_cnt <= drain_cnt + 1'b1;
					if (drain_cnt == 2'(DRAIN_CYCLES - 1)) begin
						o_dump_start <= 1'b1;
						state        <= SEQ_DUMP;
					end
				end
				SEQ_DUMP: begin
					if (i_dump_done)
						state <= SEQ_IDLE;
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// operand register
	always_ff @(posedge clk) begin
		if (accept) begin
			o_pixel   <= i_pixel;
			o_weights <= i_weights;
			o_addr    <= addr;
			o_first   <= first;
		end
	end

	// reader finishes only while we wait for it
	a_done_in_dump: assert property (@(posedge clk) disable iff (reset)
		i_dump_done |-> (state == SEQ_DUMP));

endmodule

`default_nettype wire

//--- src/mac_lane_array.sv
//////////////////////////////
// four lane mac pipeline
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mac_lane_array (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_op_valid,
	input  mac_pkg::pixel_t       i_pixel,
	input  mac_pkg::weight_word_t i_weights,
	input  mac_pkg::hid_addr_t    i_addr,
	input  logic                  i_first,
	input  mac_pkg::acc_word_t    i_rdata,   // old word, one cycle after o_raddr
	output mac_pkg::hid_addr_t    o_raddr,
	output logic                  o_write,
	output mac_pkg::hid_addr_t    o_waddr,
	output mac_pkg::acc_word_t    o_wdata
);
	import mac_pkg::*;

	logic                    s1_valid;
	hid_addr_t               s1_addr;
	logic                    s1_first;
	logic signed [ACC_W-1:0] s1_prod [LANES];  // pixel * weight per lane

	// read the old word while products are formed
	assign o_raddr = i_addr;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			o_write  <= 1'b0;
		end else begin
			s1_valid <= i_op_valid;
			o_write  <= s1_valid;     // two edges after the op strobe
		end
	end

	always_ff @(posedge clk) begin
		s1_addr  <= i_addr;
		s1_first <= i_first;
		o_waddr  <= s1_addr;
	end

	for (genvar l = 0; l < LANES; l++) begin : g_lane
		logic signed [WEIGHT_W-1:0] weight;
		logic signed [ACC_W-1:0]    old_acc;

		assign weight  = i_weights[l*WEIGHT_W +: WEIGHT_W];
		assign old_acc = i_rdata[l*ACC_W +: ACC_W];

		always_ff @(posedge clk) begin
			s1_prod[l] <= i_pixel * weight;   // 16x16 signed, full 32 bit
			// first pass drops whatever the word held
			o_wdata[l*ACC_W +: ACC_W] <= s1_first ? s1_prod[l] : old_acc + s1_prod[l];
		end
	end

	// the word being read has no write still in flight
	a_no_raw_hazard: assert property (@(posedge clk) disable iff (reset)
		i_op_valid |-> !(s1_valid && s1_addr == i_addr) && !(o_write && o_waddr == i_addr));

endmodule

`default_nettype wire

//--- src/hidden_ram.sv
//////////////////////////////
// hidden accumulator ram
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hidden_ram (
	input  logic               clk,
	input  logic               i_write,
	input  mac_pkg::hid_addr_t i_waddr,
	input  mac_pkg::acc_word_t i_wdata,
	input  mac_pkg::hid_addr_t i_raddr_a,  // mac read side
	input  mac_pkg::hid_addr_t i_raddr_b,  // dump read side
	output mac_pkg::acc_word_t o_rdata_a,
	output mac_pkg::acc_word_t o_rdata_b
);
	import mac_pkg::*;

	acc_word_t mem [HID_DEPTH];  // 16 x 128, cleared by the first pass

	always_ff @(posedge clk) begin
		if (i_write)
			mem[i_waddr] <= i_wdata;
	end

	// both reads registered, old data on a same edge collision
	always_ff @(posedge clk) begin
		o_rdata_a <= mem[i_raddr_a];
		o_rdata_b <= mem[i_raddr_b];
	end

endmodule

`default_nettype wire

//--- src/result_reader.sv
//////////////////////////////
// result stream out
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module result_reader (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_dump_start,
	input  mac_pkg::acc_word_t          i_rdata,
	output mac_pkg::hid_addr_t          o_raddr,
	output logic                        o_valid,
	output mac_pkg::neuron_idx_t        o_index,
	output logic signed [mac_pkg::ACC_W-1:0] o_value,
	output logic                        o_dump_done  // with index 63
);
	import mac_pkg::*;

	logic        active;
	neuron_idx_t idx;         // neuron being read this cycle
	logic        at_last_idx;

	assign at_last_idx = (idx == neuron_idx_t'(NEURONS - 1));

	// upper bits pick the word, lower bits the lane
	assign o_raddr = idx[NEURON_IDX_W-1 -: HID_ADDR_W];
	assign o_value = i_rdata[o_index[NEURON_IDX_W-HID_ADDR_W-1:0] * ACC_W +: ACC_W];

	always_ff @(posedge clk) begin
		if (reset) begin
			active      <= 1'b0;
			idx         <= '0;
			o_valid     <= 1'b0;
			o_dump_done <= 1'b0;
		end else begin
			o_valid     <= active;     // data out one cycle after its read
			o_dump_done <= active && at_last_idx;
			if (i_dump_start) begin
				active <= 1'b1;
				idx    <= '0;
			end else if (active) begin
				idx <= idx + 1'b1;
				if (at_last_idx)
					active <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		o_index <= idx;    // lane select follows the ram latency
	end

	// sequencer must not restart a dump in progress
	a_no_restart: assert property (@(posedge clk) disable iff (reset)
		i_dump_start |-> (!active && !o_valid));

endmodule

`default_nettype wire

//--- src/mac_top.sv
//////////////////////////////
// neuron accumulator top
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mac_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_start,
	input  logic                        i_valid,
	input  mac_pkg::pixel_t             i_pixel,
	input  mac_pkg::weight_word_t       i_weights,
	input  logic                        i_last,
	output logic                        o_busy,
	output logic                        o_valid,
	output mac_pkg::neuron_idx_t        o_index,
	output logic signed [mac_pkg::ACC_W-1:0] o_value,
	output logic                        o_done
);
	import mac_pkg::*;

	logic         op_valid;
	pixel_t       op_pixel;
	weight_word_t op_weights;
	hid_addr_t    op_addr;
	logic         op_first;
	hid_addr_t    raddr_a;
	acc_word_t    rdata_a;
	logic         wr_en;
	hid_addr_t    waddr;
	acc_word_t    wdata;
	hid_addr_t    raddr_b;
	acc_word_t    rdata_b;
	logic         dump_start;

	input_sequencer seq_i (
		.clk          (clk),
		.reset        (reset),
		.i_start      (i_start),
		.i_valid      (i_valid),
		.i_pixel      (i_pixel),
		.i_weights    (i_weights),
		.i_last       (i_last),
		.i_dump_done  (o_done),      // done pulse also returns to idle
		.o_busy       (o_busy),
		.o_op_valid   (op_valid),
		.o_pixel      (op_pixel),
		.o_weights    (op_weights),
		.o_addr       (op_addr),
		.o_first      (op_first),
		.o_dump_start (dump_start)
	);

	mac_lane_array mac_i (
		.clk        (clk),
		.reset      (reset),
		.i_op_valid (op_valid),
		.i_pixel    (op_pixel),
		.i_weights  (op_weights),
		.i_addr     (op_addr),
		.i_first    (op_first),
		.i_rdata    (rdata_a),
		.o_raddr    (raddr_a),
		.o_write    (wr_en),
		.o_waddr    (waddr),
		.o_wdata    (wdata)
	);

	hidden_ram ram_i (
		.clk       (clk),
		.i_write   (wr_en),
		.i_waddr   (waddr),
		.i_wdata   (wdata),
		.i_raddr_a (raddr_a),
		.i_raddr_b (raddr_b),
		.o_rdata_a (rdata_a),
		.o_rdata_b (rdata_b)
	);

	result_reader rd_i (
		.clk          (clk),
		.reset        (reset),
		.i_dump_start (dump_start),
		.i_rdata      (rdata_b),
		.o_raddr      (raddr_b),
		.o_valid      (o_valid),
		.o_index      (o_index),
		.o_value      (o_value),
		.o_dump_done  (o_done)
	);

endmodule

`default_nettype wire

//--- tb/tb_checker.sv
//////////////////////////////
// accumulator model check
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             i_start,
	input  logic                             i_valid,
	input  mac_pkg::pixel_t                  i_pixel,
	input  mac_pkg::weight_word_t            i_weights,
	input  logic                             i_last,
	input  logic                             i_busy,
	input  logic                             i_out_valid,
	input  mac_pkg::neuron_idx_t             i_index,
	input  logic signed [mac_pkg::ACC_W-1:0] i_value,
	input  logic                             i_done,
	output int                               o_error_count,
	output int                               o_layer_count,
	output int                               o_value_count
);
	import mac_pkg::*;

	typedef enum logic [1:0] {M_IDLE, M_RUN, M_DUMP} model_state_t;

	model_state_t state;
	int  sums [NEURONS];     // int math wraps at 32 bits
	int  addr;
	int  out_idx;            // next expected output index
	bit  first;
	int  errors;
	int  layers;
	int  values;

	assign o_error_count = errors;
	assign o_layer_count = layers;
	assign o_value_count = values;

	// add one accepted strobe into the four lanes of its word
	task automatic accumulate();
		logic signed [WEIGHT_W-1:0] w16;
		int pix;
		int prod;
		int n;
		pix = i_pixel;
		for (int l = 0; l < LANES; l++) begin
			w16  = i_weights[l*WEIGHT_W +: WEIGHT_W];
			prod = pix * int'(w16);
			n    = addr * LANES + l;
			sums[n] = first ? prod : sums[n] + prod;
		end
	endtask

	// sampled mid cycle, inputs and outputs both settled
	always @(negedge clk) begin
		bit to_idle;
		to_idle = 1'b0;
		if (reset) begin
			state   = M_IDLE;
			addr    = 0;
			out_idx = 0;
			first   = 1'b0;
			errors  = 0;
			layers  = 0;
			values  = 0;
		end else begin
			if (i_busy !== (state != M_IDLE)) begin
				$display("error at %0d ns: o_busy is %b, expected %b",
					$time, i_busy, state != M_IDLE);
				errors++;
			end
			if (i_out_valid === 1'b1) begin
				if (state != M_DUMP || out_idx >= NEURONS) begin
					$display("error at %0d ns: output strobe outside a dump", $time);
					errors++;
				end else begin
					if (i_index !== neuron_idx_t'(out_idx)) begin
						$display("error at %0d ns: index %0d, expected %0d",
							$time, i_index, out_idx);
						errors++;
					end
					if (i_value !== sums[out_idx]) begin
						$display("error at %0d ns: neuron %0d value %0d, expected %0d",
							$time, out_idx, i_value, sums[out_idx]);
						errors++;
					end
					out_idx++;
					values++;
				end
			end else if (state == M_DUMP && out_idx > 0 && out_idx < NEURONS) begin
				$display("error at %0d ns: gap in the output stream at %0d", $time, out_idx);
				errors++;
			end
			if (i_done === 1'b1) begin
				if (state != M_DUMP || out_idx != NEURONS || i_out_valid !== 1'b1) begin
					$display("error at %0d ns: o_done after %0d values", $time, out_idx);
					errors++;
				end
				layers++;
				to_idle = 1'b1;   // DUT drops to idle on the next edge
			end
			case (state)
				M_IDLE: begin
					if (i_start) begin
						state = M_RUN;
						addr  = 0;
						first = 1'b1;
					end
				end
				M_RUN: begin
					if (i_valid) begin
						accumulate();
						if (addr == HID_DEPTH - 1) begin
							first = 1'b0;
							if (i_last) begin      // layer ends only here
								state   = M_DUMP;
								out_idx = 0;
							end
						end
						addr = (addr + 1) % HID_DEPTH;
					end
				end
				default: ;   // drain and dump take nothing
			endcase
			if (to_idle)
				state = M_IDLE;
		end
	end

endmodule

`default_nettype wire

//--- tb/tb_top.sv
//////////////////////////////
// neuron mac testbench
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_top;
	import mac_pkg::*;

	localparam int LAYERS     = 4;
	localparam int START_WAIT = 20;    // cycles for o_busy after start
	localparam int DONE_WAIT  = 400;   // cycles for o_done after the last strobe

	logic                    clk;
	logic                    reset;
	logic                    start;
	logic                    valid;
	pixel_t                  pixel;
	weight_word_t            weights;
	logic                    last;
	logic                    busy;
	logic                    out_valid;
	neuron_idx_t             out_index;
	logic signed [ACC_W-1:0] out_value;
	logic                    done;

	int seed;
	int error_count;
	int layer_count;
	int value_count;
	bit ok;

	always #50 clk = ~clk;   // 100 ns period

	mac_top dut_i (
		.clk       (clk),
		.reset     (reset),
		.i_start   (start),
		.i_valid   (valid),
		.i_pixel   (pixel),
		.i_weights (weights),
		.i_last    (last),
		.o_busy    (busy),
		.o_valid   (out_valid),
		.o_index   (out_index),
		.o_value   (out_value),
		.o_done    (done)
	);

	tb_checker chk_i (
		.clk           (clk),
		.reset         (reset),
		.i_start       (start),
		.i_valid       (valid),
		.i_pixel       (pixel),
		.i_weights     (weights),
		.i_last        (last),
		.i_busy        (busy),
		.i_out_valid   (out_valid),
		.i_index       (out_index),
		.i_value       (out_value),
		.i_done        (done),
		.o_error_count (error_count),
		.o_layer_count (layer_count),
		.o_value_count (value_count)
	);

	task automatic next_cycle();
		@(posedge clk);
		#1;                // inputs change just after the edge
	endtask

	// strobes the DUT has to drop, start left alone
	task automatic drive_junk();
		valid   = (($random(seed) & 3) == 0);
		pixel   = pixel_t'($random(seed));
		weights = {$random(seed), $random(seed)};
		last    = 1'($random(seed));
	endtask

	// operands, heavy means extreme values so sums wrap
	task automatic pick_operands(input bit heavy);
		int r;
		r = $random(seed);
		if (heavy) begin
			pixel   = 16'sh8000;
			weights = {LANES{16'h8000}};   // each product is 2^30
		end else begin
			case (r & 7)
				0: pixel = 16'sh8000;    // most negative
				1: pixel = 16'sh7fff;
				default: pixel = pixel_t'(r >>> 8);
			endcase
			weights = {$random(seed), $random(seed)};
		end
	endtask

	task automatic run_layer(input int n_pix, input bit heavy, output bit layer_ok);
		int wait_cnt;
		int gap;
		int p;
		int a;
		layer_ok = 1'b1;
		gap = 2 + ($random(seed) & 3);
		repeat (gap) begin        // idle, nothing may be accepted
			drive_junk();
			next_cycle();
		end
		valid = 1'b0;
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		wait_cnt = 0;
		while (!busy && wait_cnt < START_WAIT) begin
			next_cycle();
			wait_cnt++;
		end
		if (!busy) begin
			$display("timeout at %0d ns: o_busy did not rise after start", $time);
			layer_ok = 1'b0;
		end else begin
			for (p = 0; p < n_pix; p++) begin
				for (a = 0; a < HID_DEPTH; a++) begin
					valid = 1'b0;
					gap   = $random(seed) & 3;
					while (gap > 1) begin     // random gap, start while busy
						start = (($random(seed) & 7) == 0);
						next_cycle();
						gap--;
					end
					valid = 1'b1;
					start = (($random(seed) & 7) == 0);
					pick_operands(heavy);
					if (a == HID_DEPTH - 1)
						last = (p == n_pix - 1);
					else
						last = (($random(seed) & 7) == 0);   // stray last
					next_cycle();
				end
			end
			valid = 1'b0;
			start = 1'b0;
			last  = 1'b0;
			wait_cnt = 0;
			while (!done && wait_cnt < DONE_WAIT) begin
				drive_junk();          // drain and dump ignore inputs
				next_cycle();
				wait_cnt++;
			end
			valid = 1'b0;
			if (!done) begin
				$display("timeout at %0d ns: o_done never pulsed", $time);
				layer_ok = 1'b0;
			end
		end
	endtask

	initial begin
		seed    = 56076;
		clk     = 1'b0;
		reset   = 1'b1;
		start   = 1'b0;
		valid   = 1'b0;
		pixel   = '0;
		weights = '0;
		last    = 1'b0;
		ok      = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int n = 0; n < LAYERS && ok; n++)
			run_layer(2 + ($random(seed) & 3), n == 2, ok);
		repeat (4) next_cycle();
		$display("errors %0d, layers %0d of %0d, values %0d, timeout %0d",
			error_count, layer_count, LAYERS, value_count, !ok);
		if (ok && error_count == 0 && layer_count == LAYERS)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
src/mac_pkg.sv
src/input_sequencer.sv
src/mac_lane_array.sv
src/hidden_ram.sv
src/result_reader.sv
src/mac_top.sv
tb/tb_checker.sv
tb/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
